/* design/cshPkg.sv */
`default_nettype none

package cshPkg;

  localparam int numWays = 4;

  typedef logic [1:0] wayT;

  // Per-way directory match results for one lookup
  typedef struct packed {
    logic [numWays-1:0] validMatch;
    logic [numWays-1:0] wordValid;
    logic [numWays-1:0] anyWritten;
    wayT                lruWay;
  } lookupT;

  typedef enum logic [1:0] {coreRead, writeback, wordWrite} memKindT;

  typedef struct packed {
    logic    valid;
    memKindT kind;
    wayT     way;
  } memReqT;

  typedef struct packed {
    logic writeEn;
    logic fromMem;
    wayT  way;
  } cacheWrT;

  typedef struct packed {
    logic valid;
    logic write;
  } eboxReqT;

  typedef struct packed {
    logic done;
    logic hit;
  } respT;

  typedef enum logic [1:0] {idle, eboxCyc, chanCyc} cycleT;

  function automatic logic anyValidMatch(lookupT lk);
    return |lk.validMatch;
  endfunction

  // Line present and the addressed word loaded
  function automatic logic readFound(lookupT lk);
    return |(lk.validMatch & lk.wordValid);
  endfunction

  // Lowest matching way, or the LRU way on a miss
  function automatic wayT victimWay(lookupT lk);
    wayT way;
    way = lk.lruWay;
    for (int i = numWays - 1; i >= 0; i--) begin
      if (lk.validMatch[i]) begin
        way = wayT'(i);
      end
    end
    return way;
  endfunction

  function automatic logic victimDirty(lookupT lk);
    return !anyValidMatch(lk) && lk.anyWritten[lk.lruWay];
  endfunction

endpackage

`default_nettype wire

/* design/cshArbiter.sv */
`default_nettype none

module cshArbiter (
  input  logic            clk,
  input  logic            reset,
  input  cshPkg::eboxReqT eboxReq,
  input  logic            chanReq,
  input  logic            eboxDone,
  input  logic            chanDone,
  output cshPkg::cycleT   cycle
);

  // Ready-to-go stage between sampling and the cycle start
  cshPkg::cycleT granted;
  cshPkg::cycleT grantIn;
  logic          cycEnd;

  // Channel ahead of the EBOX
  always_comb begin
    grantIn = cshPkg::idle;
    if (chanReq) begin
      grantIn = cshPkg::chanCyc;
    end else if (eboxReq.valid) begin
      grantIn = cshPkg::eboxCyc;
    end
  end

  assign cycEnd = (cycle == cshPkg::eboxCyc && eboxDone) ||
                  (cycle == cshPkg::chanCyc && chanDone);

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle   <= cshPkg::idle;
      granted <= cshPkg::idle;
    end else begin
      if (cycle == cshPkg::idle && granted == cshPkg::idle) begin
        granted <= grantIn;
      end else begin
        granted <= cshPkg::idle;
      end

      // Cycle type holds until its own done
      if (granted != cshPkg::idle) begin
        cycle <= granted;
      end else if (cycEnd) begin
        cycle <= cshPkg::idle;
      end
    end
  end

  // No cycle module may finish without a grant
  assert property (@(posedge clk) disable iff (reset)
    (eboxDone || chanDone) |-> cycle != cshPkg::idle);

endmodule

`default_nettype wire

/* design/cshEboxCycle.sv */
`default_nettype none

module cshEboxCycle (
  input  logic            clk,
  input  logic            reset,
  input  cshPkg::eboxReqT eboxReq,
  input  cshPkg::cycleT   cycle,
  input  cshPkg::lookupT  lookup,
  input  logic            stall,
  input  logic            accepted,
  input  logic            fill,
  output cshPkg::memReqT  memReq,
  output cshPkg::cacheWrT cacheWrite,
  output cshPkg::respT    eboxResp,
  output logic            cycDone
);

  logic         t0;
  logic         t1;
  logic         t2;
  logic         t3;
  logic         active;
  logic         isWrite;
  logic         hitNow;
  logic         missQ;
  logic         missDirty;
  cshPkg::wayT  missWay;
  logic         wbReq;
  logic         rdReq;
  logic         wwReq;
  logic         fillWait;
  logic         wordDone;
  cshPkg::respT respQ;

  assign t0 = cycle == cshPkg::eboxCyc && !active && eboxReq.valid;

  // A write needs only the line, a read also needs the word
  assign hitNow = isWrite ? cshPkg::anyValidMatch(lookup) : cshPkg::readFound(lookup);

  always_ff @(posedge clk) begin
    if (reset) begin
      t1         <= 1'b0;
      t2         <= 1'b0;
      t3         <= 1'b0;
      active     <= 1'b0;
      missQ      <= 1'b0;
      wbReq      <= 1'b0;
      rdReq      <= 1'b0;
      wwReq      <= 1'b0;
      fillWait   <= 1'b0;
      respQ      <= '0;
      cacheWrite <= '0;
    end else begin
      t1    <= t0;
      t2    <= t1;
      t3    <= t2;
      missQ <= t2 && !hitNow;

      if (t0) begin
        active <= 1'b1;
      end else if (cycDone) begin
        active <= 1'b0;
      end

      respQ      <= '0;
      cacheWrite <= '0;

      if (t2 && hitNow) begin
        respQ <= '{done: 1'b1, hit: 1'b1};
        if (isWrite) begin
          cacheWrite <= '{writeEn: 1'b1, fromMem: 1'b0, way: cshPkg::victimWay(lookup)};
        end
      end

      // Miss sequence starts after T3
      if (t3 && missQ) begin
        wwReq <= isWrite;
        wbReq <= !isWrite && missDirty;
        rdReq <= !isWrite && !missDirty;
      end else if (accepted) begin
        wwReq    <= 1'b0;
        wbReq    <= 1'b0;
        rdReq    <= wbReq;
        fillWait <= rdReq;
      end

      if (fill && fillWait) begin
        fillWait   <= 1'b0;
        cacheWrite <= '{writeEn: 1'b1, fromMem: 1'b1, way: missWay};
      end

      // Refill done one cycle after the fill write
      if (cacheWrite.writeEn && cacheWrite.fromMem) begin
        respQ <= '{done: 1'b1, hit: 1'b0};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (t0) begin
      isWrite <= eboxReq.write;
    end
    if (t2) begin
      missWay   <= cshPkg::victimWay(lookup);
      missDirty <= cshPkg::victimDirty(lookup);
    end
  end

  always_comb begin
    memReq.valid = wbReq || rdReq || wwReq;
    if (wbReq) begin
      memReq.kind = cshPkg::writeback;
    end else if (rdReq) begin
      memReq.kind = cshPkg::coreRead;
    end else begin
      memReq.kind = cshPkg::wordWrite;
    end
    memReq.way = missWay;
  end

  // Write miss ends as soon as memory takes the word
  assign wordDone      = wwReq && accepted;
  assign eboxResp.done = respQ.done || wordDone;
  assign eboxResp.hit  = respQ.hit;
  assign cycDone       = eboxResp.done;

  assert property (@(posedge clk) disable iff (reset)
    cacheWrite.writeEn |-> cycle == cshPkg::eboxCyc);

  // Held request while out of credits
  assert property (@(posedge clk) disable iff (reset)
    stall |=> memReq.valid && $stable(memReq));

endmodule

`default_nettype wire

/* design/cshChannelCycle.sv */
`default_nettype none

module cshChannelCycle (
  input  logic           clk,
  input  logic           reset,
  input  cshPkg::cycleT  cycle,
  input  cshPkg::lookupT lookup,
  input  logic           stall,
  input  logic           accepted,
  input  logic           fill,
  output cshPkg::memReqT memReq,
  output cshPkg::respT   chanResp,
  output logic           cycDone
);

  logic t1;
  logic t2;
  logic t3;
  logic active;
  logic rdReq;
  logic fillWait;

  // Channel cycle enters at T1
  assign t1 = cycle == cshPkg::chanCyc && !active;

  always_ff @(posedge clk) begin
    if (reset) begin
      t2       <= 1'b0;
      t3       <= 1'b0;
      active   <= 1'b0;
      rdReq    <= 1'b0;
      fillWait <= 1'b0;
      chanResp <= '0;
    end else begin
      t2 <= t1;
      t3 <= t2;

      if (t1) begin
        active <= 1'b1;
      end else if (cycDone) begin
        active <= 1'b0;
      end

      chanResp <= '0;

      if (t3) begin
        if (cshPkg::readFound(lookup)) begin
          chanResp <= '{done: 1'b1, hit: 1'b1};
        end else begin
          rdReq <= 1'b1;
        end
      end

      if (rdReq && accepted) begin
        rdReq    <= 1'b0;
        fillWait <= 1'b1;
      end

      if (fill && fillWait) begin
        fillWait <= 1'b0;
        chanResp <= '{done: 1'b1, hit: 1'b0};
      end
    end
  end

  // Served from memory, no cache way involved
  assign memReq  = '{valid: rdReq, kind: cshPkg::coreRead, way: '0};
  assign cycDone = chanResp.done;

  assert property (@(posedge clk) disable iff (reset)
    stall |=> memReq.valid);

endmodule

`default_nettype wire

/* design/cshMemPort.sv */
`default_nettype none

module cshMemPort #(
  parameter int memCredits = 2
) (
  input  logic           clk,
  input  logic           reset,
  input  cshPkg::memReqT eboxMemReq,
  input  cshPkg::memReqT chanMemReq,
  input  logic           memCredit,
  input  logic           memData,
  output cshPkg::memReqT memReq,
  output logic           eboxStall,
  output logic           chanStall,
  output logic           eboxAccepted,
  output logic           chanAccepted,
  output logic           eboxFill,
  output logic           chanFill
);

  localparam int cntW   = $clog2(memCredits + 1);
  localparam int qDepth = 4;
  localparam int ptrW   = $clog2(qDepth);

  logic [cntW-1:0]   credits;
  logic              haveCredit;
  cshPkg::memReqT    active;
  logic              fromChan;
  logic              accept;
  logic              pushRead;
  logic [qDepth-1:0] ownerQ;
  logic [ptrW-1:0]   wrPtr;
  logic [ptrW-1:0]   rdPtr;
  logic              headChan;

  // Only one cycle module is active, EBOX taken if both show up
  assign fromChan   = !eboxMemReq.valid;
  assign active     = fromChan ? chanMemReq : eboxMemReq;
  assign haveCredit = credits != '0;
  assign accept     = active.valid && haveCredit;
  assign pushRead   = accept && active.kind == cshPkg::coreRead;

  assign memReq = accept ? active : '0;

  assign eboxAccepted = accept && !fromChan;
  assign chanAccepted = accept && fromChan;
  assign eboxStall    = eboxMemReq.valid && !haveCredit;
  assign chanStall    = chanMemReq.valid && (eboxMemReq.valid || !haveCredit);

  // Read data returns in request order
  assign headChan = ownerQ[rdPtr];
  assign eboxFill = memData && !headChan;
  assign chanFill = memData && headChan;

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= cntW'(memCredits);
      wrPtr   <= '0;
      rdPtr   <= '0;
    end else begin
      case ({accept, memCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      if (pushRead) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (memData) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pushRead) begin
      ownerQ[wrPtr] <= fromChan;
    end
  end

  // Memory must not return more credits than it was given
  assert property (@(posedge clk) disable iff (reset)
    credits <= memCredits);

endmodule

`default_nettype wire

/* design/cshSequencer.sv */
`default_nettype none

module cshSequencer #(
  parameter int memCredits = 2
) (
  input  logic            clk,
  input  logic            reset,
  input  cshPkg::eboxReqT eboxReq,
  input  logic            chanReq,
  input  cshPkg::lookupT  lookup,
  input  logic            memCredit,
  input  logic            memData,
  output cshPkg::respT    eboxResp,
  output cshPkg::respT    chanResp,
  output cshPkg::memReqT  memReq,
  output cshPkg::cacheWrT cacheWrite
);

  cshPkg::cycleT  cycle;
  cshPkg::memReqT eboxMemReq;
  cshPkg::memReqT chanMemReq;
  logic           eboxStall;
  logic           chanStall;
  logic           eboxAccepted;
  logic           chanAccepted;
  logic           eboxFill;
  logic           chanFill;
  logic           eboxDone;
  logic           chanDone;

  cshArbiter arbiter (
    .clk      (clk),
    .reset    (reset),
    .eboxReq  (eboxReq),
    .chanReq  (chanReq),
    .eboxDone (eboxDone),
    .chanDone (chanDone),
    .cycle    (cycle)
  );

  cshEboxCycle eboxCycle (
    .clk        (clk),
    .reset      (reset),
    .eboxReq    (eboxReq),
    .cycle      (cycle),
    .lookup     (lookup),
    .stall      (eboxStall),
    .accepted   (eboxAccepted),
    .fill       (eboxFill),
    .memReq     (eboxMemReq),
    .cacheWrite (cacheWrite),
    .eboxResp   (eboxResp),
    .cycDone    (eboxDone)
  );

  cshChannelCycle chanCycle (
    .clk      (clk),
    .reset    (reset),
    .cycle    (cycle),
    .lookup   (lookup),
    .stall    (chanStall),
    .accepted (chanAccepted),
    .fill     (chanFill),
    .memReq   (chanMemReq),
    .chanResp (chanResp),
    .cycDone  (chanDone)
  );

  cshMemPort #(
    .memCredits (memCredits)
  ) memPort (
    .clk          (clk),
    .reset        (reset),
    .eboxMemReq   (eboxMemReq),
    .chanMemReq   (chanMemReq),
    .memCredit    (memCredit),
    .memData      (memData),
    .memReq       (memReq),
    .eboxStall    (eboxStall),
    .chanStall    (chanStall),
    .eboxAccepted (eboxAccepted),
    .chanAccepted (chanAccepted),
    .eboxFill     (eboxFill),
    .chanFill     (chanFill)
  );

endmodule

`default_nettype wire

/* testbench/cshSequencerTests.svh */
`default_nettype none

function automatic cshPkg::lookupT makeLookup(logic [3:0] match, logic [3:0] word,
                                              logic [3:0] written, cshPkg::wayT lru);
  cshPkg::lookupT lk;
  lk.validMatch = match;
  lk.wordValid  = word;
  lk.anyWritten = written;
  lk.lruWay     = lru;
  return lk;
endfunction

task automatic idleCycles(int count);
  repeat (count) @(posedge clk);
endtask

task automatic waitMemIdle();
  int n;
  n = 0;
  while (!memIdle) begin
    if (n == waitLimit) begin
      timeoutAbort("memory model drain");
    end
    @(posedge clk);
    n++;
  end
endtask

task automatic waitMemCount(int count);
  int n;
  n = 0;
  while (memLog.size() < count) begin
    if (n == waitLimit) begin
      timeoutAbort("memory request");
    end
    @(posedge clk);
    n++;
  end
endtask

task automatic beginTest();
  waitMemIdle();
  memLog.delete();
  memCyc.delete();
  wrLog.delete();
  wrCyc.delete();
  dataCyc.delete();
  creditCyc.delete();
endtask

task automatic endTest(int num, string name, int errorsBefore);
  testCount++;
  if (errorCount == errorsBefore) begin
    $display("test %0d %s: passed", num, name);
  end else begin
    failedTests++;
    $display("test %0d %s: failed with %0d errors", num, name, errorCount - errorsBefore);
  end
endtask

// Arbiter samples on the edge after the drive
task automatic issueRequest(input logic toEbox, input logic write, input logic toChan,
                            input cshPkg::lookupT lk, output int sampleAt);
  @(negedge clk);
  sampleAt = cycleNum + 2;
  @(posedge clk);
  lookup        <= lk;
  eboxReq.valid <= toEbox;
  eboxReq.write <= write;
  chanReq       <= toChan;
endtask

// Requests drop on the edge after their done
task automatic waitResponses(input logic wantEbox, input logic wantChan,
                             output int eboxAt, output logic eboxHit,
                             output int chanAt, output logic chanHit);
  int n;
  eboxAt  = -1;
  chanAt  = -1;
  eboxHit = 1'b0;
  chanHit = 1'b0;
  n       = 0;
  while ((wantEbox && eboxAt < 0) || (wantChan && chanAt < 0)) begin
    if (n == waitLimit) begin
      timeoutAbort("response done");
    end
    @(negedge clk);
    if (eboxResp.done && eboxAt < 0) begin
      eboxAt  = cycleNum;
      eboxHit = eboxResp.hit;
    end
    if (chanResp.done && chanAt < 0) begin
      chanAt  = cycleNum;
      chanHit = chanResp.hit;
    end
    @(posedge clk);
    if (eboxAt >= 0) begin
      eboxReq.valid <= 1'b0;
    end
    if (chanAt >= 0) begin
      chanReq <= 1'b0;
    end
    n++;
  end
endtask

task automatic checkRead(int idx, cshPkg::wayT way);
  if (memLog.size() <= idx) begin
    reportError("core read missing");
  end else if (memLog[idx].kind != cshPkg::coreRead || memLog[idx].way != way) begin
    reportError($sformatf("expected core read to way %0d, saw kind %0d way %0d",
                          way, memLog[idx].kind, memLog[idx].way));
  end
endtask

// Fill write one cycle after data, done one cycle after that
task automatic checkRefill(int eboxAt, logic hit, cshPkg::wayT way);
  if (wrLog.size() != 1 || dataCyc.size() != 1) begin
    reportError($sformatf("saw %0d cache writes and %0d data returns, expected one each",
                          wrLog.size(), dataCyc.size()));
  end else begin
    if (!wrLog[0].fromMem || wrLog[0].way != way) begin
      reportError($sformatf("fill write to way %0d fromMem %0d", wrLog[0].way,
                            wrLog[0].fromMem));
    end
    if (wrCyc[0] != dataCyc[0] + 1) begin
      reportError("fill write not one cycle after memory data");
    end
    if (eboxAt != wrCyc[0] + 1) begin
      reportError("refill done not one cycle after the fill write");
    end
  end
  if (hit !== 1'b0) begin
    reportError("refill answered with hit=1");
  end
endtask

task automatic testReadHit();
  int   errs;
  int   sampleAt;
  int   eboxAt;
  int   chanAt;
  logic eboxHit;
  logic chanHit;
  errs = errorCount;
  beginTest();
  issueRequest(1'b1, 1'b0, 1'b0, makeLookup(4'b0100, 4'b0100, 4'b0000, 2'd0), sampleAt);
  waitResponses(1'b1, 1'b0, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(4);
  if (eboxAt != sampleAt + 4) begin
    reportError($sformatf("read hit done after %0d cycles, expected 4", eboxAt - sampleAt));
  end
  if (eboxHit !== 1'b1) begin
    reportError("read hit answered with hit=0");
  end
  if (memLog.size() != 0 || wrLog.size() != 0) begin
    reportError("read hit touched memory or the cache");
  end
  endTest(1, "EBOX read hit", errs);
endtask

task automatic testReadMiss();
  int   errs;
  int   sampleAt;
  int   eboxAt;
  int   chanAt;
  logic eboxHit;
  logic chanHit;
  errs = errorCount;
  // Clean LRU victim in way 2
  beginTest();
  issueRequest(1'b1, 1'b0, 1'b0, makeLookup(4'b0000, 4'b0000, 4'b0001, 2'd2), sampleAt);
  waitResponses(1'b1, 1'b0, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(2);
  if (memLog.size() != 1) begin
    reportError($sformatf("clean miss issued %0d memory requests", memLog.size()));
  end
  checkRead(0, 2'd2);
  checkRefill(eboxAt, eboxHit, 2'd2);
  // Way 3 matches but its word is missing
  beginTest();
  issueRequest(1'b1, 1'b0, 1'b0, makeLookup(4'b1000, 4'b0000, 4'b1111, 2'd1), sampleAt);
  waitResponses(1'b1, 1'b0, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(2);
  if (memLog.size() != 1) begin
    reportError($sformatf("word miss issued %0d memory requests", memLog.size()));
  end
  checkRead(0, 2'd3);
  checkRefill(eboxAt, eboxHit, 2'd3);
  endTest(2, "EBOX read miss", errs);
endtask

task automatic testDirtyMiss();
  int   errs;
  int   sampleAt;
  int   eboxAt;
  int   chanAt;
  logic eboxHit;
  logic chanHit;
  errs = errorCount;
  beginTest();
  issueRequest(1'b1, 1'b0, 1'b0, makeLookup(4'b0000, 4'b0000, 4'b0010, 2'd1), sampleAt);
  waitResponses(1'b1, 1'b0, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(2);
  if (memLog.size() != 2) begin
    reportError($sformatf("dirty miss issued %0d memory requests", memLog.size()));
  end else if (memLog[0].kind != cshPkg::writeback || memLog[0].way != 2'd1) begin
    reportError("first request of a dirty miss is not a writeback of way 1");
  end
  checkRead(1, 2'd1);
  checkRefill(eboxAt, eboxHit, 2'd1);
  endTest(3, "EBOX dirty miss", errs);
endtask

task automatic testWrite();
  int   errs;
  int   sampleAt;
  int   eboxAt;
  int   chanAt;
  logic eboxHit;
  logic chanHit;
  errs = errorCount;
  beginTest();
  issueRequest(1'b1, 1'b1, 1'b0, makeLookup(4'b0010, 4'b0000, 4'b0000, 2'd3), sampleAt);
  waitResponses(1'b1, 1'b0, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(4);
  if (eboxAt != sampleAt + 4 || eboxHit !== 1'b1) begin
    reportError("write hit not done with hit=1 after 4 cycles");
  end
  if (wrLog.size() != 1 || memLog.size() != 0) begin
    reportError("write hit needs one cache write and no memory request");
  end else if (wrLog[0].fromMem || wrLog[0].way != 2'd1 || wrCyc[0] != eboxAt) begin
    reportError("write hit cache write has wrong source, way or cycle");
  end
  beginTest();
  issueRequest(1'b1, 1'b1, 1'b0, makeLookup(4'b0000, 4'b1111, 4'b1111, 2'd3), sampleAt);
  waitResponses(1'b1, 1'b0, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(4);
  if (memLog.size() != 1 || wrLog.size() != 0) begin
    reportError("write miss needs one memory request and no cache write");
  end else if (memLog[0].kind != cshPkg::wordWrite || memCyc[0] != eboxAt) begin
    reportError("write miss not done in the cycle its word write was taken");
  end
  if (eboxHit !== 1'b0) begin
    reportError("write miss answered with hit=1");
  end
  endTest(4, "EBOX write", errs);
endtask

task automatic testChannel();
  int   errs;
  int   sampleAt;
  int   eboxAt;
  int   chanAt;
  logic eboxHit;
  logic chanHit;
  errs = errorCount;
  beginTest();
  issueRequest(1'b1, 1'b0, 1'b1, makeLookup(4'b0001, 4'b0001, 4'b0000, 2'd0), sampleAt);
  waitResponses(1'b1, 1'b1, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(2);
  if (chanAt >= eboxAt || !chanHit || !eboxHit) begin
    reportError("channel did not finish first with both requests hitting");
  end
  beginTest();
  issueRequest(1'b0, 1'b0, 1'b1, makeLookup(4'b0100, 4'b0100, 4'b0000, 2'd0), sampleAt);
  waitResponses(1'b0, 1'b1, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(4);
  if (chanAt != sampleAt + 4 || chanHit !== 1'b1 || memLog.size() != 0) begin
    reportError("channel hit not done with hit=1 after 4 cycles");
  end
  // Line present, word absent
  beginTest();
  issueRequest(1'b0, 1'b0, 1'b1, makeLookup(4'b0010, 4'b0000, 4'b0000, 2'd0), sampleAt);
  waitResponses(1'b0, 1'b1, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(2);
  if (memLog.size() != 1 || memLog[0].kind != cshPkg::coreRead) begin
    reportError("channel miss did not issue exactly one core read");
  end
  if (dataCyc.size() != 1 || chanAt != dataCyc[0] + 1 || chanHit !== 1'b0) begin
    reportError("channel miss not done with hit=0 one cycle after memory data");
  end
  if (wrLog.size() != 0) begin
    reportError("channel miss wrote the cache");
  end
  endTest(5, "channel", errs);
endtask

task automatic testCreditStall();
  int   errs;
  int   sampleAt;
  int   eboxAt;
  int   chanAt;
  logic eboxHit;
  logic chanHit;
  int   i;
  errs = errorCount;
  beginTest();
  @(posedge clk);
  holdCredits <= 1'b1;
  // Channel misses soak up all but one credit
  for (i = 1; i < memCredits; i++) begin
    issueRequest(1'b0, 1'b0, 1'b1, makeLookup(4'b0000, 4'b0000, 4'b0000, 2'd0), sampleAt);
    waitResponses(1'b0, 1'b1, eboxAt, eboxHit, chanAt, chanHit);
  end
  idleCycles(2);
  memLog.delete();
  memCyc.delete();
  wrLog.delete();
  wrCyc.delete();
  dataCyc.delete();
  creditCyc.delete();
  issueRequest(1'b1, 1'b0, 1'b0, makeLookup(4'b0000, 4'b0000, 4'b0100, 2'd2), sampleAt);
  waitMemCount(1);
  idleCycles(8);
  if (memLog.size() != 1) begin
    reportError("memory request issued while no credit was left");
  end
  if (memLog[0].kind != cshPkg::writeback || memLog[0].way != 2'd2) begin
    reportError("stalled miss did not start with a writeback of way 2");
  end
  @(posedge clk);
  holdCredits <= 1'b0;
  waitResponses(1'b1, 1'b0, eboxAt, eboxHit, chanAt, chanHit);
  idleCycles(2);
  checkRead(1, 2'd2);
  if (memLog.size() >= 2 && (creditCyc.size() == 0 || memCyc[1] <= creditCyc[0])) begin
    reportError("core read went out before a credit came back");
  end
  checkRefill(eboxAt, eboxHit, 2'd2);
  endTest(6, "credit back-pressure", errs);
endtask

`default_nettype wire

/* testbench/cshSequencerTb.sv */
`default_nettype none

module cshSequencerTb #(
  parameter int memCredits = 2
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int waitLimit = 200;

  logic            clk = 1'b0;
  logic            reset;
  cshPkg::eboxReqT eboxReq;
  logic            chanReq;
  cshPkg::lookupT  lookup;
  logic            memCredit;
  logic            memData;
  cshPkg::respT    eboxResp;
  cshPkg::respT    chanResp;
  cshPkg::memReqT  memReq;
  cshPkg::cacheWrT cacheWrite;

  int              cycleNum = 0;
  int              readQ[$];
  int              creditQ[$];
  int              heldCount = 0;
  logic            holdCredits = 1'b0;
  logic            memIdle = 1'b1;
  cshPkg::memReqT  memLog[$];
  int              memCyc[$];
  cshPkg::cacheWrT wrLog[$];
  int              wrCyc[$];
  int              dataCyc[$];
  int              creditCyc[$];
  int              errorCount = 0;
  int              testCount = 0;
  int              failedTests = 0;

  cshSequencer #(
    .memCredits (memCredits)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .eboxReq    (eboxReq),
    .chanReq    (chanReq),
    .lookup     (lookup),
    .memCredit  (memCredit),
    .memData    (memData),
    .eboxResp   (eboxResp),
    .chanResp   (chanResp),
    .memReq     (memReq),
    .cacheWrite (cacheWrite)
  );

  always #4 clk = ~clk;

  // Memory returns read data and credits in request order
  always @(posedge clk) begin
    cycleNum  <= cycleNum + 1;
    memData   <= 1'b0;
    memCredit <= 1'b0;
    if (readQ.size() > 0) begin
      if (readQ[0] == 0) begin
        memData <= 1'b1;
        readQ.delete(0);
      end else begin
        readQ[0] = readQ[0] - 1;
      end
    end
    if (!holdCredits && heldCount > 0) begin
      creditQ.push_back(0);
      heldCount--;
    end
    if (creditQ.size() > 0) begin
      if (creditQ[0] == 0) begin
        memCredit <= 1'b1;
        creditQ.delete(0);
      end else begin
        creditQ[0] = creditQ[0] - 1;
      end
    end
  end

  // Outputs are logged mid-cycle where they are settled
  always @(negedge clk) begin
    if (!reset) begin
      if (memReq.valid) begin
        memLog.push_back(memReq);
        memCyc.push_back(cycleNum);
        if (memReq.kind == cshPkg::coreRead) begin
          readQ.push_back($urandom_range(0, 5));
        end
        if (holdCredits) begin
          heldCount++;
        end else begin
          creditQ.push_back($urandom_range(0, 6));
        end
      end
      if (cacheWrite.writeEn) begin
        wrLog.push_back(cacheWrite);
        wrCyc.push_back(cycleNum);
      end
      if (memData) begin
        dataCyc.push_back(cycleNum);
      end
      if (memCredit) begin
        creditCyc.push_back(cycleNum);
      end
    end
    memIdle = readQ.size() == 0 && creditQ.size() == 0 && heldCount == 0;
  end

  task automatic reportError(string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errorCount++;
  endtask

  task automatic timeoutAbort(string what);
    $display("Timeout: %s did not happen within %0d cycles", what, waitLimit);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  initial begin
    void'($urandom(32'hfc12));
    reset     = 1'b1;
    eboxReq   = '0;
    chanReq   = 1'b0;
    lookup    = '0;
    memCredit = 1'b0;
    memData   = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    idleCycles(2);

    testReadHit();
    testReadMiss();
    testDirtyMiss();
    testWrite();
    testChannel();
    testCreditStall();

    $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  `include "cshSequencerTests.svh"

endmodule

`default_nettype wire

/* cshSequencer.f */
+incdir+testbench
design/cshPkg.sv
design/cshArbiter.sv
design/cshEboxCycle.sv
design/cshChannelCycle.sv
design/cshMemPort.sv
design/cshSequencer.sv
testbench/cshSequencerTb.sv
